/* rtl/wm_defs.svh */
// Compile-time sizing of the write master
// WM_FIFO_DEPTH must be a power of two; the data width is a multiple of 8
`ifndef WM_DEFS_SVH
`define WM_DEFS_SVH

// Bus widths
`define WM_ADDR_WIDTH       32
`define WM_DATA_WIDTH       32
`define WM_XFER_SIZE_WIDTH  16

// Bytes per data word and its log2
`define WM_STRB_WIDTH       (`WM_DATA_WIDTH / 8)
`define WM_LOG_BYTES        ($clog2(`WM_STRB_WIDTH))

// Burst limited by 256 beats and by the 4 KB boundary
`define WM_BURST_BEATS      (((4096 / `WM_STRB_WIDTH) < 256) ? (4096 / `WM_STRB_WIDTH) : 256)
`define WM_LOG_BURST        ($clog2(`WM_BURST_BEATS))
`define WM_BURST_BYTES      (`WM_STRB_WIDTH * `WM_BURST_BEATS)

// Addresses issued without a response
`define WM_MAX_OUTSTANDING  4

// Words in the stream buffer
`define WM_FIFO_DEPTH       32

`endif

/* rtl/wm_pkg.sv */
// Types shared by the command latch, the burst writer and the top level
// Transfer length is held as beats minus one; sizes of zero are not supported
`default_nettype none
`include "wm_defs.svh"

package wm_pkg;

  // Beat count width after dropping the byte-in-word bits
  localparam int LEN_WIDTH    = `WM_XFER_SIZE_WIDTH - `WM_LOG_BYTES;
  // Width of the count of full bursts beyond the first
  localparam int NBURST_WIDTH = LEN_WIDTH - `WM_LOG_BURST;

  // Burst view of the beat count
  typedef struct packed {
    logic [NBURST_WIDTH-1:0]  bursts;    // full bursts before the final one
    logic [`WM_LOG_BURST-1:0] last_len;  // final burst length minus one
  } xfer_split_t;

  // Total beats minus one, read flat or split into bursts
  typedef union packed {
    logic [LEN_WIDTH-1:0] beats;
    xfer_split_t          split;
  } xfer_len_u;

  // Byte strobe of one data word
  typedef logic [`WM_STRB_WIDTH-1:0] strb_t;

endpackage

`default_nettype wire

/* rtl/wm_cmd_latch.sv */
// Captures one command per ctrl_start; the address is forced to a burst boundary
// Inputs are sampled only in the ctrl_start cycle; size must be nonzero
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module wm_cmd_latch (
  input  wire                           aclk,
  input  wire                           areset,
  input  wire                           ctrl_start,
  input  wire [`WM_ADDR_WIDTH-1:0]      ctrl_addr_offset,
  input  wire [`WM_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output logic                          start,
  output logic [`WM_ADDR_WIDTH-1:0]     burst_addr,
  output wm_pkg::xfer_len_u             xfer_len,
  output wm_pkg::strb_t                 final_strb
);
  import wm_pkg::*;

  // Low address bits inside one burst
  localparam logic [`WM_ADDR_WIDTH-1:0] ADDR_MASK = `WM_ADDR_WIDTH'(`WM_BURST_BYTES - 1);

  logic [LEN_WIDTH-1:0]     size_words;
  logic [`WM_LOG_BYTES-1:0] size_rem;
  logic [`WM_LOG_BYTES-1:0] rem_r;
  logic                     start_d1;

  // Whole words and leftover bytes of the requested size
  assign size_words = ctrl_xfer_size_in_bytes[`WM_XFER_SIZE_WIDTH-1:`WM_LOG_BYTES];
  assign size_rem   = ctrl_xfer_size_in_bytes[`WM_LOG_BYTES-1:0];

  //////////////////////////////////////////////////////////////////////
  // Capture stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A leftover byte adds a word, so it cancels the minus one
      xfer_len.beats <= (size_rem != '0) ? size_words : size_words - 1'b1;
      burst_addr     <= ctrl_addr_offset & ~ADDR_MASK;
      rem_r          <= size_rem;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Final strobe stage
  //////////////////////////////////////////////////////////////////////
  // Low rem bytes set, full word when nothing is left over
  always_ff @(posedge aclk) begin
    for (int i = 0; i < `WM_STRB_WIDTH; i++) begin
      final_strb[i] <= (rem_r == '0) || (i < rem_r);
    end
  end

  // Start lines up with the strobe, two cycles after the command
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

endmodule

`default_nettype wire

/* rtl/wm_data_fifo.sv */
// Single-clock FWFT buffer between the stream and the W channel
// Holds WM_FIFO_DEPTH words in memory plus one in the output register
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module wm_data_fifo (
  input  wire                       aclk,
  input  wire                       areset,
  input  wire                       s_axis_tvalid,
  input  wire [`WM_DATA_WIDTH-1:0]  s_axis_tdata,
  input  wire                       fifo_pop,
  output logic                      s_axis_tready,
  output logic                      fifo_valid,
  output logic [`WM_DATA_WIDTH-1:0] fifo_data
);
  localparam int PTR_W = $clog2(`WM_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [`WM_DATA_WIDTH-1:0] mem [`WM_FIFO_DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          count;
  logic                      push;
  logic                      out_load;
  logic                      mem_empty;
  logic                      bypass;
  logic                      mem_wr;
  logic                      mem_rd;

  assign s_axis_tready = (count != CNT_W'(`WM_FIFO_DEPTH));
  assign push          = s_axis_tvalid & s_axis_tready;
  assign mem_empty     = (count == '0);
  // Output register is free or being drained this cycle
  assign out_load      = ~fifo_valid | fifo_pop;
  // Incoming word goes straight to the output when memory is empty
  assign bypass        = out_load & mem_empty & push;
  assign mem_rd        = out_load & ~mem_empty;
  assign mem_wr        = push & ~bypass;

  // Pointers, occupancy and output valid
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fifo_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(mem_wr) - CNT_W'(mem_rd);
      if (out_load) begin
        fifo_valid <= mem_rd | push;
      end
    end
  end

  // Storage and output word
  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= s_axis_tdata;
    end
    if (mem_rd) begin
      fifo_data <= mem[rd_ptr];
    end else if (bypass) begin
      fifo_data <= s_axis_tdata;
    end
  end

endmodule

`default_nettype wire

/* rtl/wm_burst_writer.sv */
// Drives AW and W from the buffer and counts B responses to completion
// bready is taken as always high; one transfer at a time, new start after done
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module wm_burst_writer (
  input  wire                       aclk,
  input  wire                       areset,
  input  wire                       start,
  input  wire [`WM_ADDR_WIDTH-1:0]  burst_addr,
  input  wm_pkg::xfer_len_u         xfer_len,
  input  wm_pkg::strb_t             final_strb,
  input  wire                       fifo_valid,
  input  wire [`WM_DATA_WIDTH-1:0]  fifo_data,
  input  wire                       m_axi_awready,
  input  wire                       m_axi_wready,
  input  wire                       m_axi_bvalid,
  output logic                      fifo_pop,
  output logic                      m_axi_awvalid,
  output logic [`WM_ADDR_WIDTH-1:0] m_axi_awaddr,
  output logic [7:0]                m_axi_awlen,
  output logic                      m_axi_wvalid,
  output logic [`WM_DATA_WIDTH-1:0] m_axi_wdata,
  output wm_pkg::strb_t             m_axi_wstrb,
  output logic                      m_axi_wlast,
  output logic                      ctrl_done
);
  import wm_pkg::*;

  localparam int         BCNT_W     = NBURST_WIDTH;
  localparam int         PEND_W     = BCNT_W + 1;
  localparam int         VAC_W      = $clog2(`WM_MAX_OUTSTANDING + 1);
  localparam logic [7:0] FULL_AWLEN = 8'(`WM_BURST_BEATS - 1);

  // Data channel
  logic                     running;
  logic                     wxfer;
  logic                     wfirst;
  logic                     w_final_burst;
  logic                     w_final_xfer;
  logic [`WM_LOG_BURST-1:0] beats_left;
  logic [BCNT_W-1:0]        w_bursts_left;
  // Address channel
  logic                     awxfer;
  logic                     wfirst_d1;
  logic                     first_beat;
  logic                     aw_idle;
  logic                     stall_aw;
  logic [PEND_W-1:0]        aw_pending;
  logic [BCNT_W-1:0]        aw_bursts_left;
  // Response channel
  logic [BCNT_W-1:0]        b_bursts_left;
  logic [VAC_W-1:0]         vacancy;

  //////////////////////////////////////////////////////////////////////
  // Write data channel
  //////////////////////////////////////////////////////////////////////
  // Buffer data reaches W only while a transfer is running
  assign m_axi_wvalid  = fifo_valid & running;
  assign m_axi_wdata   = fifo_data;
  assign wxfer         = m_axi_wvalid & m_axi_wready;
  assign fifo_pop      = wxfer;
  assign m_axi_wlast   = (beats_left == '0);
  assign w_final_burst = (w_bursts_left == '0);
  assign w_final_xfer  = wxfer & m_axi_wlast & w_final_burst;
  // Partial strobe only on the very last beat
  assign m_axi_wstrb   = (m_axi_wlast & w_final_burst) ? final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (w_final_xfer) begin
      running <= 1'b0;
    end
  end

  // Beats left in the burst count down to wlast; full bursts wrap from zero
  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left    <= '1;
      w_bursts_left <= '0;
      wfirst        <= 1'b1;
    end else if (start) begin
      beats_left    <= (xfer_len.split.bursts == '0) ? xfer_len.split.last_len : '1;
      w_bursts_left <= xfer_len.split.bursts;
    end else if (wxfer) begin
      wfirst <= m_axi_wlast;
      if (m_axi_wlast) begin
        // Next burst is the final one
        beats_left    <= (w_bursts_left == BCNT_W'(1)) ? xfer_len.split.last_len : '1;
        w_bursts_left <= w_bursts_left - 1'b1;
      end else begin
        beats_left <= beats_left - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write address channel
  //////////////////////////////////////////////////////////////////////
  // One pulse when a burst's first beat shows up on W
  assign first_beat = m_axi_wvalid & wfirst & ~wfirst_d1;
  assign awxfer     = m_axi_awvalid & m_axi_awready;
  assign aw_idle    = (aw_pending == '0);
  assign stall_aw   = (vacancy == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst_d1     <= 1'b0;
      aw_pending    <= '0;
      m_axi_awvalid <= 1'b0;
    end else begin
      wfirst_d1  <= m_axi_wvalid & wfirst;
      // Bursts with data on the way but no address yet
      aw_pending <= aw_pending + PEND_W'(first_beat) - PEND_W'(awxfer);
      if (m_axi_awvalid) begin
        if (m_axi_awready) begin
          m_axi_awvalid <= 1'b0;
        end
      end else if (!aw_idle && !stall_aw) begin
        m_axi_awvalid <= 1'b1;
      end
    end
  end

  // Address steps by one burst per handshake
  always_ff @(posedge aclk) begin
    if (start) begin
      m_axi_awaddr <= burst_addr;
    end else if (awxfer) begin
      m_axi_awaddr <= m_axi_awaddr + `WM_ADDR_WIDTH'(`WM_BURST_BYTES);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_bursts_left <= '0;
    end else if (start) begin
      aw_bursts_left <= xfer_len.split.bursts;
    end else if (awxfer) begin
      aw_bursts_left <= aw_bursts_left - 1'b1;
    end
  end

  // Final burst gets the short length
  assign m_axi_awlen = (aw_bursts_left == '0) ? 8'(xfer_len.split.last_len) : FULL_AWLEN;

  //////////////////////////////////////////////////////////////////////
  // Write response channel
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      b_bursts_left <= '0;
      vacancy       <= VAC_W'(`WM_MAX_OUTSTANDING);
      ctrl_done     <= 1'b0;
    end else begin
      // Done one cycle after the last response
      ctrl_done <= m_axi_bvalid & (b_bursts_left == '0);
      if (start) begin
        b_bursts_left <= xfer_len.split.bursts;
      end else if (m_axi_bvalid) begin
        b_bursts_left <= b_bursts_left - 1'b1;
      end
      // Free address slots that hold off AW at zero
      vacancy <= vacancy + VAC_W'(m_axi_bvalid) - VAC_W'(awxfer);
    end
  end

endmodule

`default_nettype wire

/* rtl/wm_write_master.sv */
// Stream to AXI4 write master, single clock; bready is assumed tied high
// Start address is rounded down to a WM_BURST_BYTES boundary
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module wm_write_master (
  input  wire                       aclk,
  input  wire                       areset,
  input  wire                       ctrl_start,
  input  wire [`WM_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  wire [`WM_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output wire                       ctrl_done,
  input  wire                       s_axis_tvalid,
  input  wire [`WM_DATA_WIDTH-1:0]  s_axis_tdata,
  output wire                       s_axis_tready,
  output wire                       m_axi_awvalid,
  input  wire                       m_axi_awready,
  output wire [`WM_ADDR_WIDTH-1:0]  m_axi_awaddr,
  output wire [7:0]                 m_axi_awlen,
  output wire                       m_axi_wvalid,
  input  wire                       m_axi_wready,
  output wire [`WM_DATA_WIDTH-1:0]  m_axi_wdata,
  output wire [`WM_STRB_WIDTH-1:0]  m_axi_wstrb,
  output wire                       m_axi_wlast,
  input  wire                       m_axi_bvalid
);
  import wm_pkg::*;

  // Command to writer
  logic                      start;
  logic [`WM_ADDR_WIDTH-1:0] burst_addr;
  xfer_len_u                 xfer_len;
  strb_t                     final_strb;
  // Buffer to writer
  logic                      fifo_valid;
  logic [`WM_DATA_WIDTH-1:0] fifo_data;
  logic                      fifo_pop;

  wm_cmd_latch u_cmd (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size_in_bytes,
    .start, .burst_addr, .xfer_len, .final_strb
  );

  wm_data_fifo u_fifo (
    .aclk, .areset, .s_axis_tvalid, .s_axis_tdata, .fifo_pop,
    .s_axis_tready, .fifo_valid, .fifo_data
  );

  wm_burst_writer u_writer (
    .aclk, .areset, .start, .burst_addr, .xfer_len, .final_strb,
    .fifo_valid, .fifo_data, .m_axi_awready, .m_axi_wready, .m_axi_bvalid,
    .fifo_pop, .m_axi_awvalid, .m_axi_awaddr, .m_axi_awlen,
    .m_axi_wvalid, .m_axi_wdata, .m_axi_wstrb, .m_axi_wlast, .ctrl_done
  );

endmodule

`default_nettype wire

/* tests/wm_sva.sv */
// Protocol assertions bound into every wm_write_master instance
// Outstanding count assumes each bvalid answers an earlier AW handshake
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module wm_sva (
  input wire                      aclk,
  input wire                      areset,
  input wire                      ctrl_done,
  input wire                      m_axi_awvalid,
  input wire                      m_axi_awready,
  input wire [`WM_ADDR_WIDTH-1:0] m_axi_awaddr,
  input wire [7:0]                m_axi_awlen,
  input wire                      m_axi_wvalid,
  input wire                      m_axi_wready,
  input wire [`WM_DATA_WIDTH-1:0] m_axi_wdata,
  input wire [`WM_STRB_WIDTH-1:0] m_axi_wstrb,
  input wire                      m_axi_wlast,
  input wire                      m_axi_bvalid
);

  int unsigned fail_count = 0;
  logic [3:0]  outstanding;

  // Addresses accepted and not yet answered
  always_ff @(posedge aclk) begin
    if (areset) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(m_axi_awvalid & m_axi_awready) - 4'(m_axi_bvalid);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Channel stability and limits
  //////////////////////////////////////////////////////////////////////
  aw_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
    else begin
      $error("AW changed while stalled");
      fail_count++;
    end

  w_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb) && $stable(m_axi_wlast))
    else begin
      $error("W changed while stalled");
      fail_count++;
    end

  pending_limit: assert property (@(posedge aclk) disable iff (areset)
    outstanding <= 4'(`WM_MAX_OUTSTANDING))
    else begin
      $error("too many addresses without response");
      fail_count++;
    end

  // Done is a single-cycle pulse
  done_pulse: assert property (@(posedge aclk) disable iff (areset)
    ctrl_done |=> !ctrl_done)
    else begin
      $error("ctrl_done high in consecutive cycles");
      fail_count++;
    end

endmodule

bind wm_write_master wm_sva u_sva (
  .aclk, .areset, .ctrl_done, .m_axi_awvalid, .m_axi_awready, .m_axi_awaddr,
  .m_axi_awlen, .m_axi_wvalid, .m_axi_wready, .m_axi_wdata, .m_axi_wstrb,
  .m_axi_wlast, .m_axi_bvalid
);

`default_nettype wire

/* tests/tb_write_master.sv */
// Testbench for wm_write_master with a byte-level AXI4 memory model
// Stream words count up from 0 in every transfer; bready is taken as high
// W beats may come before their AW; the model pairs them in order
`timescale 1ns/1ns
`default_nettype none
`include "wm_defs.svh"

module tb_write_master;

  localparam int MAX_WAIT = 20000;
  localparam int SW       = `WM_STRB_WIDTH;
  localparam int BEATS    = `WM_BURST_BEATS;
  localparam int BBYTES   = `WM_BURST_BYTES;

  // DUT inputs
  logic                           aclk = 1'b0;
  logic                           areset;
  logic                           ctrl_start;
  logic [`WM_ADDR_WIDTH-1:0]      ctrl_addr_offset;
  logic [`WM_XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes;
  logic                           s_axis_tvalid;
  logic [`WM_DATA_WIDTH-1:0]      s_axis_tdata;
  logic                           m_axi_awready = 1'b0;
  logic                           m_axi_wready = 1'b0;
  logic                           m_axi_bvalid = 1'b0;
  // DUT outputs
  wire                            ctrl_done;
  wire                            s_axis_tready;
  wire                            m_axi_awvalid;
  wire  [`WM_ADDR_WIDTH-1:0]      m_axi_awaddr;
  wire  [7:0]                     m_axi_awlen;
  wire                            m_axi_wvalid;
  wire  [`WM_DATA_WIDTH-1:0]      m_axi_wdata;
  wire  [SW-1:0]                  m_axi_wstrb;
  wire                            m_axi_wlast;

  integer seed = 49;
  // Test knobs
  bit rand_ready = 1'b0;
  bit hold_b     = 1'b0;
  bit gap_now    = 1'b0;
  // Current transfer
  logic [`WM_ADDR_WIDTH-1:0] cur_base;
  int cur_size, cur_words, cur_rem, cur_bursts;
  // Memory model state
  logic [7:0]                mem [logic [31:0]];
  logic [`WM_ADDR_WIDTH-1:0] aw_addr_q[$];
  logic [7:0]                aw_len_q[$];
  logic [`WM_ADDR_WIDTH-1:0] aw_log_addr[$];
  logic [7:0]                aw_log_len[$];
  logic [`WM_DATA_WIDTH-1:0] w_data_q[$];
  logic [SW-1:0]             w_strb_q[$];
  logic                      w_last_q[$];
  int drain_beat, w_cnt, b_owed, b_seen, done_cnt;
  int cycle = 0;
  int last_b_cycle = -100;
  // Report counts
  int errors = 0;
  int err_mark = 0;
  int ntests = 0;
  int npass = 0;

  wm_write_master dut0 (.*);

  always #2 aclk = ~aclk;

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("error %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic flag_problem(input string what);
    $display("%0t %s", $time, what);
    errors++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////////////////////////
  // Low r strobe bytes on the very last beat and all bytes elsewhere
  task automatic check_beat();
    logic [SW-1:0] exp_strb;
    exp_strb = '1;
    if (w_cnt == cur_words - 1 && cur_rem != 0) begin
      exp_strb = SW'((1 << cur_rem) - 1);
    end
    assert (w_cnt < cur_words) else flag_problem("W beat beyond the transfer size");
    assert (m_axi_wstrb == exp_strb) else flag_mismatch("m_axi_wstrb", m_axi_wstrb, exp_strb);
  endtask

  // Write beats whose address is known, one B owed per finished burst
  task automatic drain_bursts();
    logic [`WM_ADDR_WIDTH-1:0] a;
    logic [`WM_DATA_WIDTH-1:0] d;
    while (aw_addr_q.size() > 0 && w_data_q.size() > 0) begin
      a = aw_addr_q[0] + 32'(SW * drain_beat);
      d = w_data_q[0];
      for (int i = 0; i < SW; i++) begin
        if (w_strb_q[0][i]) begin
          mem[a + 32'(i)] = d[8*i +: 8];
        end
      end
      assert (w_last_q[0] == (drain_beat == int'(aw_len_q[0])))
        else flag_problem("wlast not on beat awlen+1 of its burst");
      if (w_last_q[0]) begin
        void'(aw_addr_q.pop_front());
        void'(aw_len_q.pop_front());
        drain_beat = 0;
        b_owed++;
      end else begin
        drain_beat++;
      end
      void'(w_data_q.pop_front());
      void'(w_strb_q.pop_front());
      void'(w_last_q.pop_front());
    end
  endtask

  // Sample at the edge, then drive 1 ns later
  always begin
    @(posedge aclk);
    cycle++;
    gap_now = $random(seed) & 1;
    if (!areset) begin
      if (ctrl_done) begin
        done_cnt++;
        assert (cycle == last_b_cycle + 1)
          else flag_problem("ctrl_done not one cycle after the final bvalid");
        assert (b_seen == cur_bursts) else flag_mismatch("responses at done", b_seen, cur_bursts);
      end
      if (m_axi_bvalid) begin
        b_owed--;
        b_seen++;
        last_b_cycle = cycle;
      end
      if (m_axi_awvalid && m_axi_awready) begin
        aw_addr_q.push_back(m_axi_awaddr);
        aw_len_q.push_back(m_axi_awlen);
        aw_log_addr.push_back(m_axi_awaddr);
        aw_log_len.push_back(m_axi_awlen);
      end
      if (m_axi_wvalid && m_axi_wready) begin
        check_beat();
        w_data_q.push_back(m_axi_wdata);
        w_strb_q.push_back(m_axi_wstrb);
        w_last_q.push_back(m_axi_wlast);
        w_cnt++;
      end
      drain_bursts();
    end
    #1;
    m_axi_awready = !rand_ready || (($random(seed) & 3) != 0);
    m_axi_wready  = !rand_ready || (($random(seed) & 3) != 0);
    // Random response delay
    m_axi_bvalid  = (b_owed > 0) && !hold_b && (($random(seed) & 1) != 0);
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////////////
  task automatic start_xfer(input logic [`WM_ADDR_WIDTH-1:0] addr, input int size);
    cur_size   = size;
    cur_words  = (size + SW - 1) / SW;
    cur_rem    = size % SW;
    cur_bursts = (cur_words + BEATS - 1) / BEATS;
    cur_base   = addr & ~32'(BBYTES - 1);
    mem.delete();
    aw_log_addr.delete();
    aw_log_len.delete();
    w_cnt      = 0;
    b_seen     = 0;
    done_cnt   = 0;
    drain_beat = 0;
    @(posedge aclk);
    #1;
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = `WM_XFER_SIZE_WIDTH'(size);
    ctrl_start              = 1'b1;
    @(posedge aclk);
    #1;
    ctrl_start = 1'b0;
  endtask

  // Incrementing words, with gaps when asked
  task automatic send_stream(input int words, input bit gaps);
    int sent;
    int guard;
    sent  = 0;
    guard = 0;
    while (sent < words && guard < MAX_WAIT) begin
      @(posedge aclk);
      if (s_axis_tvalid && s_axis_tready) begin
        sent++;
      end
      guard++;
      #1;
      s_axis_tvalid = (sent < words) && (!gaps || !gap_now);
      s_axis_tdata  = `WM_DATA_WIDTH'(sent);
    end
    assert (sent == words) else flag_problem("timeout while sending stream words");
  endtask

  task automatic wait_done();
    int guard;
    guard = 0;
    while (done_cnt == 0 && guard < MAX_WAIT) begin
      @(posedge aclk);
      #1;
      guard++;
    end
    assert (done_cnt != 0) else flag_problem("timeout waiting for ctrl_done");
  endtask

  task automatic wait_beats(input int n);
    int guard;
    guard = 0;
    while (w_cnt < n && guard < MAX_WAIT) begin
      @(posedge aclk);
      #1;
      guard++;
    end
    assert (w_cnt >= n) else flag_problem("timeout waiting for W beats");
  endtask

  // Full bursts first and the remaining words in the last one
  task automatic check_bursts();
    logic [7:0] exp_len;
    assert (aw_log_addr.size() == cur_bursts)
      else flag_mismatch("AW handshakes", aw_log_addr.size(), cur_bursts);
    for (int i = 0; i < cur_bursts && i < aw_log_addr.size(); i++) begin
      exp_len = (i == cur_bursts - 1) ? 8'(cur_words - 1 - BEATS * i) : 8'(BEATS - 1);
      assert (aw_log_addr[i] == cur_base + 32'(BBYTES * i))
        else flag_mismatch("m_axi_awaddr", aw_log_addr[i], cur_base + 32'(BBYTES * i));
      assert (aw_log_len[i] == exp_len) else flag_mismatch("m_axi_awlen", aw_log_len[i], exp_len);
    end
  endtask

  // Word k holds value k at base plus 4k; nothing past the size
  task automatic check_memory();
    logic [31:0] a;
    logic [7:0]  exp;
    for (int k = 0; k < cur_words * SW; k++) begin
      a   = cur_base + 32'(k);
      exp = 8'((k / SW) >> (8 * (k % SW)));
      if (k < cur_size) begin
        assert (mem.exists(a)) else flag_problem($sformatf("byte at 0x%h never written", a));
        if (mem.exists(a)) begin
          assert (mem[a] == exp) else flag_mismatch($sformatf("mem[0x%h]", a), mem[a], exp);
        end
      end else begin
        assert (!mem.exists(a)) else flag_problem($sformatf("byte at 0x%h written past size", a));
      end
    end
    assert (mem.num() == cur_size) else flag_mismatch("bytes written", mem.num(), cur_size);
  endtask

  task automatic check_xfer();
    repeat (4) @(posedge aclk);
    #1;
    check_bursts();
    check_memory();
    assert (done_cnt == 1) else flag_mismatch("ctrl_done pulses", done_cnt, 1);
    assert (b_seen == cur_bursts) else flag_mismatch("m_axi_bvalid count", b_seen, cur_bursts);
  endtask

  task automatic plain_xfer(input logic [`WM_ADDR_WIDTH-1:0] addr, input int size,
                            input bit gaps);
    start_xfer(addr, size);
    fork
      send_stream(cur_words, gaps);
      wait_done();
    join
    check_xfer();
  endtask

  task automatic end_test(input string name);
    ntests++;
    if (errors == err_mark) begin
      npass++;
      $display("test %0d %s: pass", ntests, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", ntests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    s_axis_tvalid           = 1'b0;
    s_axis_tdata            = '0;
    repeat (10) @(posedge aclk);
    #1;
    areset = 1'b0;

    plain_xfer(32'h0000_2000, 64, 1'b0);
    end_test("short transfer");
    // Remainders of 3 and 2 bytes
    plain_xfer(32'h0000_8000, 151, 1'b0);
    plain_xfer(32'h0000_8400, 46, 1'b0);
    end_test("partial final word");
    plain_xfer(32'h0000_4123, 2600, 1'b0);
    end_test("multi-burst");
    rand_ready = 1'b1;
    plain_xfer(32'h0001_0200, 1500, 1'b1);
    end_test("back-pressure");

    // All data goes out while responses are held back
    hold_b = 1'b1;
    start_xfer(32'h0002_0000, 6144);
    fork
      send_stream(cur_words, 1'b0);
      wait_beats(cur_words);
    join
    repeat (16) @(posedge aclk);
    #1;
    assert (aw_log_addr.size() <= `WM_MAX_OUTSTANDING)
      else flag_mismatch("AW handshakes while held", aw_log_addr.size(), `WM_MAX_OUTSTANDING);
    hold_b = 1'b0;
    wait_done();
    check_xfer();
    end_test("outstanding limit");

    $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             ntests, npass, ntests - npass, errors, dut0.u_sva.fail_count);
    if (errors == 0 && dut0.u_sva.fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/wm_pkg.sv
rtl/wm_cmd_latch.sv
rtl/wm_data_fifo.sv
rtl/wm_burst_writer.sv
rtl/wm_write_master.sv
tests/wm_sva.sv
tests/tb_write_master.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_write_master
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
